// ==== verilog/adc_udp_cfg.svh ====
//////////////////////////////////////////////////////////////////////
// ADC to UDP streamer configuration
// Frame size, FIFO depth, ADC clock divider and UDP header fields
//////////////////////////////////////////////////////////////////////

`ifndef ADC_UDP_CFG_SVH
`define ADC_UDP_CFG_SVH

// ADC sampling
`define ADC_WIDTH      10
`define ADC_DIV        4

// Framing, two bytes per sample
`define FRAME_SAMPLES  8
`define FRAME_BYTES    16

// Must be a power of two
`define FIFO_DEPTH     64

// UDP header fields
`define UDP_SRC_PORT   1234
`define UDP_DST_PORT   9999
`define UDP_HDR_BYTES  8

`endif

// ==== verilog/adc_udp_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared types for the ADC to UDP streamer
//////////////////////////////////////////////////////////////////////

`include "adc_udp_cfg.svh"

package adc_udp_pkg;

    // One byte on a framed byte stream
    typedef logic [7:0] byte_t;

    // Raw ADC sample
    typedef logic [`ADC_WIDTH-1:0] sample_t;

    // FIFO address width
    localparam int FIFO_AW = $clog2(`FIFO_DEPTH);

    // Extra MSB tells full from empty
    typedef logic [FIFO_AW:0] fifo_ptr_t;

    // Index into the 8-byte UDP header
    typedef logic [2:0] hdr_idx_t;

endpackage

// ==== verilog/byte_stream_if.sv ====
//////////////////////////////////////////////////////////////////////
// Framed byte stream with valid/ready handshake and end-of-frame flag
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface byte_stream_if;

    adc_udp_pkg::byte_t data;
    logic               valid;
    logic               ready;
    logic               last;

    modport source (
        output data,
        output valid,
        output last,
        input  ready
    );

    modport sink (
        input  data,
        input  valid,
        input  last,
        output ready
    );

endinterface

// ==== verilog/adc_frame_packer.sv ====
//////////////////////////////////////////////////////////////////////
// ADC capture and packer
// Generates the ADC clock, samples the ADC bus and emits each sample
// as two bytes, grouped into fixed-size frames
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "adc_udp_cfg.svh"

module adc_frame_packer (
    input  logic                 clk,
    input  logic                 rst,
    input  adc_udp_pkg::sample_t adc_data,
    input  logic                 start,
    input  logic                 stop,
    output logic                 adc_clk,
    byte_stream_if.source        bytes
);

    localparam int DIV_W = $clog2(`ADC_DIV);
    localparam int CNT_W = $clog2(`FRAME_SAMPLES);

    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`ADC_DIV - 1);
    // Divider value just before adc_clk goes high
    localparam logic [DIV_W-1:0] DIV_RISE = DIV_W'(`ADC_DIV / 2 - 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`FRAME_SAMPLES - 1);

    logic [DIV_W-1:0]     div_cnt;
    logic                 capturing;
    adc_udp_pkg::sample_t sample;
    logic                 byte_valid;
    logic                 phase;
    logic [CNT_W-1:0]     sample_cnt;
    logic                 take_sample;

    //////////////////////////////////////////////////////////////////////
    // ADC clock
    //////////////////////////////////////////////////////////////////////

    // Low for the first half of the period, high for the second
    assign adc_clk     = capturing && (div_cnt > DIV_RISE);
    assign take_sample = capturing && (div_cnt == DIV_RISE);

    always_ff @(posedge clk) begin
        if (rst) begin
            capturing <= 1'b0;
            div_cnt   <= '0;
        end else if (!capturing) begin
            div_cnt <= '0;
            if (start) begin
                capturing <= 1'b1;
            end
        end else begin
            div_cnt <= (div_cnt == DIV_LAST) ? '0 : div_cnt + 1'b1;
            // Stop only takes effect once a frame is complete
            if (bytes.last && stop) begin
                capturing <= 1'b0;
                div_cnt   <= '0;
            end
        end
    end

    // Sample register
    always_ff @(posedge clk) begin
        if (take_sample) begin
            sample <= adc_data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Byte packing
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            byte_valid <= 1'b0;
            phase      <= 1'b0;
            sample_cnt <= '0;
        end else if (take_sample) begin
            byte_valid <= 1'b1;
            phase      <= 1'b0;
        end else if (byte_valid) begin
            if (!phase) begin
                phase <= 1'b1;
            end else begin
                byte_valid <= 1'b0;
                phase      <= 1'b0;
                sample_cnt <= (sample_cnt == CNT_LAST) ? '0 : sample_cnt + 1'b1;
            end
        end
    end

    // High byte first, zero-extended
    assign bytes.data  = phase ? sample[7:0]
                               : adc_udp_pkg::byte_t'(sample[`ADC_WIDTH-1:8]);
    assign bytes.valid = byte_valid;
    assign bytes.last  = byte_valid && phase && (sample_cnt == CNT_LAST);

endmodule

// ==== verilog/frame_fifo.sv ====
//////////////////////////////////////////////////////////////////////
// Frame FIFO
// Releases a frame only once its last byte is stored; a frame that
// does not fit is discarded whole
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "adc_udp_cfg.svh"

module frame_fifo (
    input  logic        clk,
    input  logic        rst,
    byte_stream_if.sink wr,
    byte_stream_if.source rd,
    output logic        frame_dropped
);

    localparam int AW = adc_udp_pkg::FIFO_AW;

    adc_udp_pkg::byte_t    mem      [`FIFO_DEPTH];
    logic                  last_mem [`FIFO_DEPTH];
    adc_udp_pkg::fifo_ptr_t wr_ptr;
    adc_udp_pkg::fifo_ptr_t commit_ptr;
    adc_udp_pkg::fifo_ptr_t rd_ptr;
    logic                  dropping;
    logic                  full;
    logic                  wr_en;
    logic                  discard;
    logic                  rd_en;

    //////////////////////////////////////////////////////////////////////
    // Write side
    //////////////////////////////////////////////////////////////////////

    // Producer never stalls
    assign wr.ready = 1'b1;

    assign full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign wr_en   = wr.valid && wr.ready;
    assign discard = dropping || full;

    // Flags the last byte of a discarded frame
    assign frame_dropped = wr_en && wr.last && discard;

    always_ff @(posedge clk) begin
        if (wr_en && !discard) begin
            mem[wr_ptr[AW-1:0]]      <= wr.data;
            last_mem[wr_ptr[AW-1:0]] <= wr.last;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            rd_ptr     <= '0;
            dropping   <= 1'b0;
        end else begin
            if (wr_en) begin
                if (discard) begin
                    // Rewind to the start of the partial frame
                    wr_ptr   <= commit_ptr;
                    dropping <= !wr.last;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                    if (wr.last) begin
                        commit_ptr <= wr_ptr + 1'b1;
                    end
                end
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read side, committed data only
    //////////////////////////////////////////////////////////////////////

    assign rd.valid = (rd_ptr != commit_ptr);
    assign rd.data  = mem[rd_ptr[AW-1:0]];
    assign rd.last  = last_mem[rd_ptr[AW-1:0]];
    assign rd_en    = rd.valid && rd.ready;

endmodule

// ==== verilog/udp_frame_tx.sv ====
//////////////////////////////////////////////////////////////////////
// UDP transmitter
// Prepends the 8-byte UDP header to each frame and shows the first
// payload byte on the LEDs
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "adc_udp_cfg.svh"

module udp_frame_tx (
    input  logic               clk,
    input  logic               rst,
    byte_stream_if.sink        payload,
    output adc_udp_pkg::byte_t out_data,
    output logic               out_valid,
    output logic               out_last,
    input  logic               out_ready,
    output adc_udp_pkg::byte_t ledg
);

    typedef enum logic {
        ST_HDR,
        ST_PAYLOAD
    } state_t;

    localparam logic [15:0] SRC_PORT = 16'(`UDP_SRC_PORT);
    localparam logic [15:0] DST_PORT = 16'(`UDP_DST_PORT);
    localparam logic [15:0] UDP_LEN  = 16'(`UDP_HDR_BYTES + `FRAME_BYTES);
    localparam adc_udp_pkg::hdr_idx_t HDR_LAST = 3'(`UDP_HDR_BYTES - 1);

    state_t                state;
    adc_udp_pkg::hdr_idx_t hdr_idx;
    adc_udp_pkg::byte_t    hdr_byte;
    logic                  first_byte;
    logic                  out_fire;

    //////////////////////////////////////////////////////////////////////
    // Header byte select, big endian fields
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (hdr_idx)
            3'd0:    hdr_byte = SRC_PORT[15:8];
            3'd1:    hdr_byte = SRC_PORT[7:0];
            3'd2:    hdr_byte = DST_PORT[15:8];
            3'd3:    hdr_byte = DST_PORT[7:0];
            3'd4:    hdr_byte = UDP_LEN[15:8];
            3'd5:    hdr_byte = UDP_LEN[7:0];
            // Checksum not computed
            default: hdr_byte = 8'h00;
        endcase
    end

    // FIFO only shows complete frames, so valid holds for the whole frame
    assign out_valid     = payload.valid;
    assign out_data      = (state == ST_PAYLOAD) ? payload.data : hdr_byte;
    assign out_last      = (state == ST_PAYLOAD) && payload.last;
    assign payload.ready = (state == ST_PAYLOAD) && out_ready;
    assign out_fire      = out_valid && out_ready;

    //////////////////////////////////////////////////////////////////////
    // FSM and LED register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_HDR;
            hdr_idx    <= '0;
            first_byte <= 1'b0;
            ledg       <= '0;
        end else if (out_fire) begin
            case (state)
                ST_HDR: begin
                    hdr_idx <= hdr_idx + 1'b1;
                    if (hdr_idx == HDR_LAST) begin
                        state      <= ST_PAYLOAD;
                        first_byte <= 1'b1;
                    end
                end
                ST_PAYLOAD: begin
                    first_byte <= 1'b0;
                    if (first_byte) begin
                        ledg <= payload.data;
                    end
                    if (payload.last) begin
                        state <= ST_HDR;
                    end
                end
                default: state <= ST_HDR;
            endcase
        end
    end

endmodule

// ==== verilog/adc_udp_top.sv ====
//////////////////////////////////////////////////////////////////////
// ADC to UDP streamer top level
// Capture, frame buffering and UDP header insertion
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module adc_udp_top (
    input  logic                 clk,
    input  logic                 rst,
    input  adc_udp_pkg::sample_t adc_data,
    input  logic                 start,
    input  logic                 stop,
    input  logic                 out_ready,
    output logic                 adc_clk,
    output adc_udp_pkg::byte_t   out_data,
    output logic                 out_valid,
    output logic                 out_last,
    output adc_udp_pkg::byte_t   ledg,
    output logic                 frame_dropped
);

    byte_stream_if adc_bytes ();
    byte_stream_if fifo_bytes ();

    adc_frame_packer u_packer (
        .clk      (clk),
        .rst      (rst),
        .adc_data (adc_data),
        .start    (start),
        .stop     (stop),
        .adc_clk  (adc_clk),
        .bytes    (adc_bytes.source)
    );

    frame_fifo u_fifo (
        .clk           (clk),
        .rst           (rst),
        .wr            (adc_bytes.sink),
        .rd            (fifo_bytes.source),
        .frame_dropped (frame_dropped)
    );

    udp_frame_tx u_udp_tx (
        .clk       (clk),
        .rst       (rst),
        .payload   (fifo_bytes.sink),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_ready (out_ready),
        .ledg      (ledg)
    );

endmodule

// ==== tests/tb_adc_udp.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the ADC to UDP streamer
// Random ADC data checked against a frame model, stop and back-pressure
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "adc_udp_cfg.svh"

module tb_adc_udp;

    localparam int FRAME_LEN = `UDP_HDR_BYTES + `FRAME_BYTES;
    localparam int TIMEOUT   = 2000;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 start;
    logic                 stop;
    logic                 out_ready;
    adc_udp_pkg::sample_t adc_data;
    logic                 adc_clk;
    adc_udp_pkg::byte_t   out_data;
    logic                 out_valid;
    logic                 out_last;
    adc_udp_pkg::byte_t   ledg;
    logic                 frame_dropped;

    integer seed = 87;
    int     errors = 0;
    int     tests = 0;
    int     tests_failed = 0;
    int     rx_frames = 0;
    int     drops = 0;
    logic   adc_clk_prev = 1'b0;

    adc_udp_pkg::sample_t samples  [$];
    adc_udp_pkg::byte_t   rx_bytes [$];
    logic                 rx_last  [$];
    adc_udp_pkg::byte_t   rx_led   [$];

    adc_udp_top dut (.*);

    always #4 clk = ~clk;

    // ADC model, a sample is the data present where adc_clk rose
    always @(negedge clk) begin
        if (adc_clk && !adc_clk_prev) begin
            samples.push_back(adc_data);
        end
        adc_clk_prev = adc_clk;
        adc_data = adc_udp_pkg::sample_t'($random(seed));
    end

    // Output monitor
    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            rx_bytes.push_back(out_data);
            rx_last.push_back(out_last);
            if (out_last) begin
                rx_led.push_back(ledg);
                rx_frames++;
            end
        end
        if (!rst && frame_dropped) begin
            drops++;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model and checks
    //////////////////////////////////////////////////////////////////////

    // Byte idx of model frame m, UDP header then packed samples
    function automatic adc_udp_pkg::byte_t expected_byte(int m, int idx);
        logic [63:0]          hdr;
        adc_udp_pkg::sample_t s;
        hdr = {16'(`UDP_SRC_PORT), 16'(`UDP_DST_PORT), 16'(FRAME_LEN), 16'h0000};
        if (idx < `UDP_HDR_BYTES) begin
            return hdr[63 - 8 * idx -: 8];
        end
        s = samples[m * `FRAME_SAMPLES + (idx - `UDP_HDR_BYTES) / 2];
        // Top two bits first
        return (idx % 2 == 0) ? 8'(s >> 8) : s[7:0];
    endfunction

    function automatic int frame_mismatches(int r, int m, int lo, int hi, bit report);
        int                 n;
        adc_udp_pkg::byte_t exp_b;
        n = 0;
        for (int i = lo; i < hi; i++) begin
            exp_b = expected_byte(m, i);
            if (rx_bytes[r * FRAME_LEN + i] !== exp_b) begin
                n++;
                if (report) begin
                    $display("FAIL t=%0t out_data frame %0d byte %0d: got %02h expected %02h",
                             $time, r, i, rx_bytes[r * FRAME_LEN + i], exp_b);
                end
            end
        end
        return n;
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(string name, int err_start);
        tests++;
        if (errors == err_start) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, errors - err_start);
            tests_failed++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Waits and stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic wait_frames(int n);
        int t;
        t = 0;
        while (rx_frames < n && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (rx_frames < n) begin
            $display("ERROR: timed out waiting for %0d frames, got %0d", n, rx_frames);
            errors++;
        end
    endtask

    task automatic wait_drops(int n);
        int t;
        t = 0;
        while (drops < n && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (drops < n) begin
            $display("ERROR: timed out waiting for %0d dropped frames", n);
            errors++;
        end
    endtask

    // Idle once adc_clk has been low for several ADC periods
    task automatic wait_capture_idle();
        int t;
        int low;
        t = 0;
        low = 0;
        while (low < 4 * `ADC_DIV && t < TIMEOUT) begin
            @(negedge clk);
            low = adc_clk ? 0 : low + 1;
            t++;
        end
        if (low < 4 * `ADC_DIV) begin
            $display("ERROR: adc_clk still running after %0d cycles", t);
            errors++;
        end
    endtask

    task automatic pulse_start();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    initial begin
        int e;
        int gen;
        int m;
        int stop_samples;
        rst = 1'b1;
        start = 1'b0;
        stop = 1'b0;
        out_ready = 1'b0;
        adc_data = adc_udp_pkg::sample_t'($random(seed));
        repeat (4) @(negedge clk);
        rst = 1'b0;

        e = errors;
        check_value("out_valid", 32'(out_valid), 0);
        check_value("out_last", 32'(out_last), 0);
        check_value("adc_clk", 32'(adc_clk), 0);
        check_value("frame_dropped", 32'(frame_dropped), 0);
        check_value("ledg", 32'(ledg), 0);
        end_test("reset_state", e);

        // Free-running capture, stop raised partway through a frame
        out_ready = 1'b1;
        pulse_start();
        wait_frames(3);
        stop = 1'b1;
        // DUT first sees stop at this edge
        @(posedge clk);
        stop_samples = samples.size();
        wait_capture_idle();
        stop = 1'b0;
        gen = samples.size() / `FRAME_SAMPLES;
        wait_frames(gen);

        e = errors;
        for (int r = 0; r < rx_frames && r < gen; r++) begin
            errors += frame_mismatches(r, r, 0, `UDP_HDR_BYTES, 1);
        end
        end_test("udp_header", e);

        e = errors;
        for (int r = 0; r < rx_frames && r < gen; r++) begin
            errors += frame_mismatches(r, r, `UDP_HDR_BYTES, FRAME_LEN, 1);
        end
        for (int i = 0; i < rx_last.size(); i++) begin
            check_value("out_last", 32'(rx_last[i]), 32'(i % FRAME_LEN == FRAME_LEN - 1));
        end
        end_test("payload_packing", e);

        e = errors;
        for (int r = 0; r < rx_led.size() && r < gen; r++) begin
            check_value("ledg", 32'(rx_led[r]), 32'(expected_byte(r, `UDP_HDR_BYTES)));
        end
        end_test("led_byte", e);

        e = errors;
        check_value("samples past last frame", samples.size() % `FRAME_SAMPLES, 0);
        // Only the frame in progress may finish once stop is seen
        if (samples.size() - stop_samples > `FRAME_SAMPLES) begin
            $display("ERROR: %0d samples taken after stop, capture went past the open frame",
                     samples.size() - stop_samples);
            errors++;
        end
        check_value("frames received", rx_frames, gen);
        check_value("frame_dropped count", drops, 0);
        check_value("adc_clk", 32'(adc_clk), 0);
        check_value("out_valid", 32'(out_valid), 0);
        end_test("stop_at_boundary", e);

        // FIFO holds four frames while out_ready is low
        e = errors;
        samples.delete();
        rx_bytes.delete();
        rx_last.delete();
        rx_led.delete();
        rx_frames = 0;
        drops = 0;
        out_ready = 1'b0;
        pulse_start();
        wait_drops(2);
        stop = 1'b1;
        wait_capture_idle();
        stop = 1'b0;
        out_ready = 1'b1;
        gen = samples.size() / `FRAME_SAMPLES;
        wait_frames(gen - drops);
        check_value("frames received plus dropped", rx_frames + drops, gen);
        m = 0;
        for (int r = 0; r < rx_frames; r++) begin
            while (m < gen && frame_mismatches(r, m, 0, FRAME_LEN, 0) != 0) begin
                m++;
            end
            if (m >= gen) begin
                $display("ERROR: received frame %0d matches no later model frame", r);
                errors++;
                break;
            end
            m++;
        end
        end_test("backpressure_drops", e);

        $display("Tests: %0d run, %0d passed, %0d failed, %0d errors",
                 tests, tests - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+verilog
verilog/adc_udp_pkg.sv
verilog/byte_stream_if.sv
verilog/adc_frame_packer.sv
verilog/frame_fifo.sv
verilog/udp_frame_tx.sv
verilog/adc_udp_top.sv
tests/tb_adc_udp.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the ADC to UDP testbench with Verilator, run it and check the log
rm -f sim.log
verilator --binary --timing --top-module tb_adc_udp -f filelist.f -o sim_adc_udp \
    && ./obj_dir/sim_adc_udp > sim.log 2>&1
cat sim.log
grep -q "^PASS: all tests$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
